//--- logic/switch_cfg_pkg.sv
package switch_cfg_pkg;

    ////////////////////
    // lane sizing.
    ////////////////////

    localparam int DATA_WIDTH      = 32; // bits per packet word.
    localparam int PORT_COUNT      = 16;
    localparam int PRIORITY_LEVELS = 8;
    localparam int LENGTH_MAX      = 256; // number of length codes, zero is not used.

    // field widths follow from the counts above.
    localparam int WIDTH_SEL      = $clog2(PORT_COUNT);
    localparam int WIDTH_PRIORITY = $clog2(PRIORITY_LEVELS);
    localparam int WIDTH_LENGTH   = $clog2(LENGTH_MAX);

    ////////////////////
    // packet FIFO.
    ////////////////////

    localparam int FIFO_DEPTH     = 64;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH); // depth is a power of two, pointers wrap.

endpackage

//--- logic/packet_pkg.sv
package packet_pkg;

    import switch_cfg_pkg::*;

    ////////////////////
    // word format.
    ////////////////////

    // the header keeps its fields at the top, the rest is padding.
    localparam int HDR_PAD_WIDTH = DATA_WIDTH - WIDTH_SEL - WIDTH_PRIORITY - WIDTH_LENGTH;

    // payload words carry source, destination and a running index.
    localparam int SEQ_WIDTH = DATA_WIDTH - 2 * WIDTH_SEL;

    // one word, read either as a header or as a payload word.
    // the start flag alongside the word tells which view applies.
    typedef union packed {
        struct packed {
            logic [WIDTH_SEL-1:0]      dest;
            logic [WIDTH_PRIORITY-1:0] prio;
            logic [WIDTH_LENGTH-1:0]   length;
            logic [HDR_PAD_WIDTH-1:0]  pad; // always zero.
        } hdr;
        struct packed {
            logic [WIDTH_SEL-1:0] src;
            logic [WIDTH_SEL-1:0] dest;
            logic [SEQ_WIDTH-1:0] seq;
        } pay;
    } packet_word_t;

endpackage

//--- logic/packet_source.sv
`timescale 1ns/1ps

module packet_source
    import switch_cfg_pkg::*, packet_pkg::*;
#(
    parameter int unsigned tx_port = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      req,
    output logic                      ack,
    input  logic [WIDTH_SEL-1:0]      dest,
    input  logic [WIDTH_PRIORITY-1:0] prio,
    input  logic [WIDTH_LENGTH-1:0]   length,

    output logic                      wr_vld,
    output logic                      wr_sop,
    output logic                      wr_eop,
    output packet_word_t              wr_data,
    input  logic                      full
);

    // one-hot state bit positions.
    localparam int S_IDLE = 0;
    localparam int S_HDR  = 1;
    localparam int S_SEND = 2;
    localparam int S_DONE = 3;
    localparam int S_ACK  = 4;

    logic [4:0] state_q;
    logic [4:0] state_d;

    logic [WIDTH_SEL-1:0]      dest_q;
    logic [WIDTH_PRIORITY-1:0] prio_q;
    logic [WIDTH_LENGTH-1:0]   len_q;
    logic [WIDTH_LENGTH-1:0]   seq_q;

    logic wr_ok;
    logic last_word;

    assign wr_ok     = wr_vld && !full; // the FIFO takes the word this cycle.
    assign last_word = seq_q == len_q - 1'b1;

    ////////////////////
    // state machine.
    ////////////////////

    always_comb begin
        state_d = '0;
        case (1'b1)
            state_q[S_IDLE]: begin
                if (req) state_d[S_HDR] = 1'b1;
                else     state_d[S_IDLE] = 1'b1;
            end
            state_q[S_HDR]: begin
                if (wr_ok) state_d[S_SEND] = 1'b1;
                else       state_d[S_HDR] = 1'b1;
            end
            state_q[S_SEND]: begin
                if (wr_ok && last_word) state_d[S_DONE] = 1'b1;
                else                    state_d[S_SEND] = 1'b1;
            end
            state_q[S_DONE]: state_d[S_ACK] = 1'b1;
            state_q[S_ACK]: begin
                // ack stays up until the requester lets go of req.
                if (req) state_d[S_ACK] = 1'b1;
                else     state_d[S_IDLE] = 1'b1;
            end
            default: state_d[S_IDLE] = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= 5'(1 << S_IDLE);
        end else begin
            state_q <= state_d;
        end
    end

    // command is captured once, the requester may change it after ack.
    always_ff @(posedge clk) begin
        if (state_q[S_IDLE] && req) begin
            dest_q <= dest;
            prio_q <= prio;
            len_q  <= length;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq_q <= '0;
        end else if (state_q[S_IDLE]) begin
            seq_q <= '0;
        end else if (state_q[S_SEND] && wr_ok) begin
            seq_q <= seq_q + 1'b1; // only accepted words advance the index.
        end
    end

    ////////////////////
    // write side.
    ////////////////////

    assign wr_vld = state_q[S_HDR] || state_q[S_SEND];
    assign wr_sop = state_q[S_HDR];
    assign wr_eop = state_q[S_SEND] && last_word;
    assign ack    = state_q[S_ACK];

    always_comb begin
        wr_data = '0;
        if (state_q[S_HDR]) begin
            wr_data.hdr.dest   = dest_q;
            wr_data.hdr.prio   = prio_q;
            wr_data.hdr.length = len_q;
            wr_data.hdr.pad    = '0;
        end else begin
            wr_data.pay.src  = WIDTH_SEL'(tx_port);
            wr_data.pay.dest = dest_q;
            wr_data.pay.seq  = SEQ_WIDTH'(seq_q);
        end
    end

    // the requester keeps its command steady until the handshake completes.
    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req && $past(req) && !$past(ack) |-> $stable({dest, prio, length}));

    a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        state_q[S_IDLE] && req |-> length != '0);

endmodule

//--- logic/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo
    import switch_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  wr_vld,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic                  full,

    output logic                  rd_vld,
    output logic                  rd_sop,
    output logic                  rd_eop,
    output logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  rd_pop
);

    // each entry holds the word plus its start and end flags.
    logic [DATA_WIDTH+1:0] mem [FIFO_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   count; // one bit wider to reach FIFO_DEPTH.

    logic push;
    logic pop;

    assign full   = count == (FIFO_PTR_WIDTH+1)'(FIFO_DEPTH);
    assign rd_vld = count != '0;

    assign push = wr_vld && !full;
    assign pop  = rd_pop && rd_vld;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {wr_sop, wr_eop, wr_data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave the level unchanged.
            endcase
        end
    end

    // show-ahead read, the head entry is always on the outputs.
    assign {rd_sop, rd_eop, rd_data} = mem[rd_ptr];

    // a refused write is offered again unchanged.
    a_hold_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && full |=> wr_vld && $stable({wr_sop, wr_eop, wr_data}));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pop |-> rd_vld);

endmodule

//--- logic/packet_egress.sv
`timescale 1ns/1ps

module packet_egress
    import switch_cfg_pkg::*, packet_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      rd_vld,
    input  logic                      rd_sop,
    input  logic                      rd_eop,
    input  packet_word_t              rd_data,
    output logic                      rd_pop,

    output logic                      out_vld,
    input  logic                      out_ready,
    output logic                      out_sop,
    output logic                      out_eop,
    output logic [DATA_WIDTH-1:0]     out_data,
    output logic [WIDTH_SEL-1:0]      out_dest,
    output logic [WIDTH_PRIORITY-1:0] out_priority
);

    logic body_q;  // low while waiting for a header.
    logic first_q; // next transfer is the first payload word.

    logic [WIDTH_SEL-1:0]      dest_q;
    logic [WIDTH_PRIORITY-1:0] prio_q;

    logic hdr_take;
    logic xfer;

    ////////////////////
    // header decode.
    ////////////////////

    assign hdr_take = !body_q && rd_vld; // the header leaves in a single cycle.

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            dest_q <= rd_data.hdr.dest;
            prio_q <= rd_data.hdr.prio;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            body_q  <= 1'b0;
            first_q <= 1'b0;
        end else if (hdr_take) begin
            body_q  <= 1'b1;
            first_q <= 1'b1;
        end else if (xfer) begin
            first_q <= 1'b0;
            if (rd_eop) body_q <= 1'b0; // back to header phase after the last word.
        end
    end

    ////////////////////
    // payload stream.
    ////////////////////

    // the FIFO head is passed straight through, so a stall keeps it in place.
    assign out_vld  = body_q && rd_vld;
    assign xfer     = out_vld && out_ready;
    assign rd_pop   = hdr_take || xfer;

    assign out_data     = rd_data;
    assign out_sop      = first_q;
    assign out_eop      = rd_eop;
    assign out_dest     = dest_q;
    assign out_priority = prio_q;

    // a packet in the FIFO always starts with its header.
    a_hdr_has_sop: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_take |-> rd_sop);

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld && !out_ready |=> out_vld && $stable(out_data));

endmodule

//--- logic/packet_lane_top.sv
`timescale 1ns/1ps

module packet_lane_top
    import switch_cfg_pkg::*, packet_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      req,
    output logic                      ack,
    input  logic [WIDTH_SEL-1:0]      dest,
    input  logic [WIDTH_PRIORITY-1:0] prio,
    input  logic [WIDTH_LENGTH-1:0]   length,

    output logic                      out_vld,
    input  logic                      out_ready,
    output logic                      out_sop,
    output logic                      out_eop,
    output logic [DATA_WIDTH-1:0]     out_data,
    output logic [WIDTH_SEL-1:0]      out_dest,
    output logic [WIDTH_PRIORITY-1:0] out_priority
);

    // source to FIFO.
    logic         wr_vld;
    logic         wr_sop;
    logic         wr_eop;
    packet_word_t wr_data;
    logic         full;

    // FIFO to egress.
    logic                  rd_vld;
    logic                  rd_sop;
    logic                  rd_eop;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rd_pop;

    packet_source #(
        .tx_port (5)
    ) u_source (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .ack     (ack),
        .dest    (dest),
        .prio    (prio),
        .length  (length),
        .wr_vld  (wr_vld),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_data (wr_data),
        .full    (full)
    );

    packet_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_vld  (wr_vld),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_data (wr_data),
        .full    (full),
        .rd_vld  (rd_vld),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_data (rd_data),
        .rd_pop  (rd_pop)
    );

    packet_egress u_egress (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_vld       (rd_vld),
        .rd_sop       (rd_sop),
        .rd_eop       (rd_eop),
        .rd_data      (rd_data),
        .rd_pop       (rd_pop),
        .out_vld      (out_vld),
        .out_ready    (out_ready),
        .out_sop      (out_sop),
        .out_eop      (out_eop),
        .out_data     (out_data),
        .out_dest     (out_dest),
        .out_priority (out_priority)
    );

endmodule

//--- bench/packet_lane_tb.sv
`timescale 1ns/1ps

module packet_lane_tb
    import switch_cfg_pkg::*, packet_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int N_SINGLE     = 4;
    localparam int N_RANDOM     = 30;
    localparam int N_PACKETS    = N_SINGLE + 2 + N_RANDOM;
    localparam int TEST_LEN_MAX = 40;
    localparam int PKT_MARGIN   = 10; // header, handshake and drain cycles per packet.
    localparam logic [WIDTH_SEL-1:0] SRC_PORT = 5;
    localparam logic [15:0] LFSR_SEED = 16'd12640;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    typedef struct packed {
        logic [WIDTH_SEL-1:0]      dest;
        logic [WIDTH_PRIORITY-1:0] prio;
        logic [WIDTH_LENGTH-1:0]   len;
    } cmd_t;

    logic clk, rst_n, req, ack, out_vld, out_ready, out_sop, out_eop;
    logic [WIDTH_SEL-1:0]      dest, out_dest;
    logic [WIDTH_PRIORITY-1:0] prio, out_priority;
    logic [WIDTH_LENGTH-1:0]   length;
    logic [DATA_WIDTH-1:0]     out_data;

    logic [15:0] lfsr_q;
    int          errors, packets_done, word_idx, full_cycles;
    bit          req_issued, random_ready, ack_d, req_d;
    cmd_t        cmd_list [N_PACKETS];
    cmd_t        cmd_q [$]; // commands issued and not yet fully seen at the output.
    string       name_q [$];
    cmd_t        cur;

    packet_lane_top DUT (
        .clk (clk), .rst_n (rst_n), .req (req), .ack (ack), .dest (dest), .prio (prio),
        .length (length), .out_vld (out_vld), .out_ready (out_ready), .out_sop (out_sop),
        .out_eop (out_eop), .out_data (out_data), .out_dest (out_dest),
        .out_priority (out_priority)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // word i carries the source port, the destination and i.
    function automatic logic [DATA_WIDTH-1:0] expected_word(
        input logic [WIDTH_SEL-1:0] src, input logic [WIDTH_SEL-1:0] dst, input int idx);
        return {src, dst, SEQ_WIDTH'(idx)};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[6:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ LFSR_TAPS : lfsr_q >> 1; // galois step.
        end
        return v;
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAILED %s %s: expected %h, actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    ////////////////////
    // requester.
    ////////////////////

    task automatic issue_command(input cmd_t cmd, input string test, input bit check_latency);
        int cycles;
        assert (!ack) else begin
            $display("ack was still high when a new command was about to start");
            errors++;
        end
        req        = 1'b1;
        dest       = cmd.dest;
        prio       = cmd.prio;
        length     = cmd.len;
        req_issued = 1'b1;
        cmd_q.push_back(cmd);
        name_q.push_back(test);
        @(posedge clk); // the source samples req here.
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ack);
        if (check_latency) begin
            check_field(test, "ack latency", cmd.len + 2, cycles);
        end
        #1 req = 1'b0;
        @(posedge clk);
        #1;
        assert (!ack) else begin
            $display("ack did not fall one cycle after req fell");
            errors++;
        end
        #1;
    endtask

    task automatic wait_drained();
        while (cmd_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        #2;
        out_ready = random_ready ? (take_bits(1) != 0) : 1'b1;
    end

    ////////////////////
    // checking.
    ////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            if (!req_issued) begin
                assert (!ack && !out_vld) else begin
                    $display("ack or out_vld went high before the first command");
                    errors++;
                end
            end
            if (ack && !ack_d) begin
                // req_d is what the source saw on the edge that raised ack.
                assert (req_d) else begin
                    $display("ack rose while req was low");
                    errors++;
                end
            end
            if (DUT.full) full_cycles++;
        end
        ack_d = ack;
        req_d = req;
    end

    always @(posedge clk) begin
        if (rst_n && out_vld && out_ready) begin
            assert (cmd_q.size() != 0) else begin
                $display("output word %h arrived with no command outstanding", out_data);
                errors++;
            end
            if (cmd_q.size() != 0) begin
                cur = cmd_q[0];
                check_field(name_q[0], "out_data",
                            expected_word(SRC_PORT, cur.dest, word_idx), out_data);
                check_field(name_q[0], "out_dest", cur.dest, out_dest);
                check_field(name_q[0], "out_priority", cur.prio, out_priority);
                check_field(name_q[0], "out_sop", word_idx == 0, out_sop);
                check_field(name_q[0], "out_eop", word_idx == cur.len - 1, out_eop);
                word_idx++;
                if (word_idx == cur.len) begin
                    word_idx = 0;
                    packets_done++;
                    void'(cmd_q.pop_front());
                    void'(name_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * 4 * (N_PACKETS * (TEST_LEN_MAX + PKT_MARGIN) + 100));
        $display("watchdog timeout, the run did not finish in time (%0d errors)", errors);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        dest      = '0;
        prio      = '0;
        length    = 8'd1;
        out_ready = 1'b0;
        lfsr_q    = LFSR_SEED;
        for (int n = 0; n < N_PACKETS; n++) begin
            cmd_list[n].dest = WIDTH_SEL'(take_bits(WIDTH_SEL));
            cmd_list[n].prio = WIDTH_PRIORITY'(take_bits(WIDTH_PRIORITY));
            cmd_list[n].len  = WIDTH_LENGTH'(take_bits(6) % TEST_LEN_MAX + 1);
        end
        cmd_list[N_SINGLE].len     = 8'd1;
        cmd_list[N_SINGLE + 1].len = 8'd40;
        repeat (10) @(posedge clk);
        assert (!ack && !out_vld) else begin
            $display("ack or out_vld high during reset");
            errors++;
        end
        #2 rst_n = 1'b1;
        repeat (5) @(posedge clk); // idle stretch before the first req.
        #2;
        for (int n = 0; n < N_SINGLE + 2; n++) begin
            if (n < N_SINGLE) issue_command(cmd_list[n], "single", 1'b1);
            else              issue_command(cmd_list[n], "length_edge", 1'b1);
            wait_drained();
        end
        @(negedge clk);
        random_ready = 1'b1;
        @(posedge clk);
        #2;
        for (int n = N_SINGLE + 2; n < N_PACKETS; n++) begin
            issue_command(cmd_list[n], "random_ready", 1'b0); // back to back.
        end
        wait_drained();
        @(negedge clk);
        random_ready = 1'b0;
        repeat (5) @(posedge clk);
        check_field("end_of_run", "out_vld", 0, out_vld);
        check_field("end_of_run", "packets", N_PACKETS, packets_done);
        assert (full_cycles > 0) else begin
            $display("the FIFO never filled under random back-pressure");
            errors++;
        end
        $display("%0d errors, %0d packets checked", errors, packets_done);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/switch_cfg_pkg.sv
logic/packet_pkg.sv
logic/packet_source.sv
logic/packet_fifo.sv
logic/packet_egress.sv
logic/packet_lane_top.sv
bench/packet_lane_tb.sv

//--- Bender.yml
package:
  name: packet_lane

sources:
  # design, packages first.
  - files:
      - logic/switch_cfg_pkg.sv
      - logic/packet_pkg.sv
      - logic/packet_source.sv
      - logic/packet_fifo.sv
      - logic/packet_egress.sv
      - logic/packet_lane_top.sv

  # bench.
  - target: simulation
    files:
      - bench/packet_lane_tb.sv
